// ==== files.f ====
hdl/mips_pkg.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/control_unit.sv
hdl/mxu.sv
hdl/mips_cpu.sv
verif/mips_cpu_tb.sv

// ==== hdl/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  mips_pkg::instr_code_t       instruction_code,
    input  logic [mips_pkg::DATA_W-1:0] rs_data,
    input  logic [15:0]                 imm,
    output logic [mips_pkg::DATA_W-1:0] alu_r
);

    logic [mips_pkg::DATA_W-1:0] imm_sext;

    assign imm_sext = {{(mips_pkg::DATA_W - 16){imm[15]}}, imm};

    always_comb begin
        if (instruction_code == mips_pkg::LUI) begin
            // Immediate into the upper half, lower half zero
            alu_r = {imm, 16'h0000};
        end else begin
            // Effective address for loads and stores, sum for ADDIU
            alu_r = rs_data + imm_sext;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/control_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        mem_halt,
    input  logic [mips_pkg::DATA_W-1:0] readdata,
    input  mips_pkg::instr_code_t       instruction_code,
    input  logic [mips_pkg::DATA_W-1:0] dataout,
    input  logic [mips_pkg::DATA_W-1:0] alu_r,
    output logic                        fetch,
    output logic                        exec1,
    output logic                        exec2,
    output logic [mips_pkg::DATA_W-1:0] pc_address,
    output logic [mips_pkg::DATA_W-1:0] instr_word,
    output logic                        reg_write,
    output logic [mips_pkg::DATA_W-1:0] write_data,
    output logic                        halted
);

    mips_pkg::cpu_state_t        state;
    logic [mips_pkg::DATA_W-1:0] pc;
    logic [mips_pkg::DATA_W-1:0] ir;
    logic [mips_pkg::DATA_W-1:0] load_q;
    logic                        is_load;
    logic                        writes_reg;

    // ----------------------------------------------------------
    // State machine and program counter
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mips_pkg::FETCH;
            pc    <= mips_pkg::RESET_PC;
        end else begin
            case (state)
                mips_pkg::FETCH: begin
                    // Leave only once the fetch read has completed
                    if (!mem_halt) begin
                        if (readdata == '0) begin
                            state <= mips_pkg::HALTED;
                        end else begin
                            state <= mips_pkg::EXEC1;
                        end
                    end
                end
                mips_pkg::EXEC1: begin
                    if (!mem_halt) begin
                        state <= mips_pkg::EXEC2;
                    end
                end
                mips_pkg::EXEC2: begin
                    state <= mips_pkg::FETCH;
                    pc    <= pc + 32'd4;
                end
                default: begin
                    state <= mips_pkg::HALTED;
                end
            endcase
        end
    end

    // Instruction register and load data capture
    always_ff @(posedge clk) begin
        if (fetch && !mem_halt) begin
            ir <= readdata;
        end
        if (exec1 && !mem_halt) begin
            load_q <= dataout;
        end
    end

    // ----------------------------------------------------------
    // Strobes and write-back
    // ----------------------------------------------------------
    // No fetch while reset is held
    assign fetch  = (state == mips_pkg::FETCH) && !rst;
    assign exec1  = (state == mips_pkg::EXEC1);
    assign exec2  = (state == mips_pkg::EXEC2);
    assign halted = (state == mips_pkg::HALTED);

    assign pc_address = pc;
    assign instr_word = ir;

    assign is_load = (instruction_code == mips_pkg::LB)  ||
                     (instruction_code == mips_pkg::LBU) ||
                     (instruction_code == mips_pkg::LH)  ||
                     (instruction_code == mips_pkg::LHU) ||
                     (instruction_code == mips_pkg::LW);

    assign writes_reg = is_load ||
                        (instruction_code == mips_pkg::LUI) ||
                        (instruction_code == mips_pkg::ADDIU);

    // Destination is always rt, written in EXEC2
    assign reg_write  = exec2 && writes_reg;
    assign write_data = is_load ? load_q : alu_r;

endmodule

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
    input  logic [mips_pkg::DATA_W-1:0]     instr_word,
    output mips_pkg::instr_code_t           instruction_code,
    output logic [mips_pkg::REG_ADDR_W-1:0] rs,
    output logic [mips_pkg::REG_ADDR_W-1:0] rt,
    output logic [15:0]                     imm
);

    logic [5:0] opcode;

    // I-type field split
    assign opcode = instr_word[31:26];
    assign rs     = instr_word[25:21];
    assign rt     = instr_word[20:16];
    assign imm    = instr_word[15:0];

    always_comb begin
        if (instr_word == '0) begin
            // All-zero word stops the core
            instruction_code = mips_pkg::HALT;
        end else begin
            case (opcode)
                mips_pkg::OP_LB: begin
                    instruction_code = mips_pkg::LB;
                end
                mips_pkg::OP_LBU: begin
                    instruction_code = mips_pkg::LBU;
                end
                mips_pkg::OP_LH: begin
                    instruction_code = mips_pkg::LH;
                end
                mips_pkg::OP_LHU: begin
                    instruction_code = mips_pkg::LHU;
                end
                mips_pkg::OP_LW: begin
                    instruction_code = mips_pkg::LW;
                end
                mips_pkg::OP_SB: begin
                    instruction_code = mips_pkg::SB;
                end
                mips_pkg::OP_SH: begin
                    instruction_code = mips_pkg::SH;
                end
                mips_pkg::OP_SW: begin
                    instruction_code = mips_pkg::SW;
                end
                mips_pkg::OP_LUI: begin
                    instruction_code = mips_pkg::LUI;
                end
                mips_pkg::OP_ADDIU: begin
                    instruction_code = mips_pkg::ADDIU;
                end
                default: begin
                    // Executed as a no-op by the control unit
                    instruction_code = mips_pkg::INVALID;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mips_cpu.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_cpu (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [mips_pkg::DATA_W-1:0] readdata,
    input  logic                        waitrequest,
    output logic [mips_pkg::DATA_W-1:0] mem_address,
    output logic                        read,
    output logic                        write,
    output logic [3:0]                  byteenable,
    output logic [mips_pkg::DATA_W-1:0] writedata,
    output logic                        halted,
    output logic [mips_pkg::DATA_W-1:0] register_v0
);

    // ----------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------
    logic                            fetch;
    logic                            exec1;
    logic [mips_pkg::DATA_W-1:0]     pc_address;
    logic [mips_pkg::DATA_W-1:0]     instr_word;
    mips_pkg::instr_code_t           instruction_code;
    logic [mips_pkg::REG_ADDR_W-1:0] rs;
    logic [mips_pkg::REG_ADDR_W-1:0] rt;
    logic [15:0]                     imm;
    logic [mips_pkg::DATA_W-1:0]     rs_data;
    logic [mips_pkg::DATA_W-1:0]     rt_data;
    logic [mips_pkg::DATA_W-1:0]     alu_r;
    logic [mips_pkg::DATA_W-1:0]     dataout;
    logic                            mem_halt;
    logic                            reg_write;
    logic [mips_pkg::DATA_W-1:0]     write_data;

    control_unit control_unit_i (
        .clk              (clk),
        .rst              (rst),
        .mem_halt         (mem_halt),
        .readdata         (readdata),
        .instruction_code (instruction_code),
        .dataout          (dataout),
        .alu_r            (alu_r),
        .fetch            (fetch),
        .exec1            (exec1),
        .exec2            (),
        .pc_address       (pc_address),
        .instr_word       (instr_word),
        .reg_write        (reg_write),
        .write_data       (write_data),
        .halted           (halted)
    );

    instr_decoder instr_decoder_i (
        .instr_word       (instr_word),
        .instruction_code (instruction_code),
        .rs               (rs),
        .rt               (rt),
        .imm              (imm)
    );

    // Write-back always targets rt
    reg_file reg_file_i (
        .clk         (clk),
        .rst         (rst),
        .rs          (rs),
        .rt          (rt),
        .reg_write   (reg_write),
        .write_addr  (rt),
        .write_data  (write_data),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .register_v0 (register_v0)
    );

    alu alu_i (
        .instruction_code (instruction_code),
        .rs_data          (rs_data),
        .imm              (imm),
        .alu_r            (alu_r)
    );

    mxu mxu_i (
        .waitrequest      (waitrequest),
        .regdatain        (rt_data),
        .memin            (readdata),
        .fetch            (fetch),
        .exec1            (exec1),
        .instruction_code (instruction_code),
        .pc_address       (pc_address),
        .alu_r            (alu_r),
        .mem_address      (mem_address),
        .dataout          (dataout),
        .memout           (writedata),
        .read             (read),
        .write            (write),
        .byteenable       (byteenable),
        .mem_halt         (mem_halt)
    );

endmodule

`default_nettype wire

// ==== hdl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    // ----------------------------------------------------------
    // Widths and reset values
    // ----------------------------------------------------------
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    // Address of the first instruction fetched after reset
    localparam logic [DATA_W-1:0] RESET_PC = 32'h0000_0000;

    // ----------------------------------------------------------
    // Primary opcodes, instruction bits 31:26
    // ----------------------------------------------------------
    localparam logic [5:0] OP_LB    = 6'h20;
    localparam logic [5:0] OP_LH    = 6'h21;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_LBU   = 6'h24;
    localparam logic [5:0] OP_LHU   = 6'h25;
    localparam logic [5:0] OP_SB    = 6'h28;
    localparam logic [5:0] OP_SH    = 6'h29;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_ADDIU = 6'h09;

    // ----------------------------------------------------------
    // Internal instruction codes
    // ----------------------------------------------------------
    // Codes 48 and 49 are reserved for the unaligned word loads
    typedef enum logic [6:0] {
        LB      = 7'd42,
        LBU     = 7'd43,
        LH      = 7'd44,
        LHU     = 7'd45,
        LUI     = 7'd46,
        LW      = 7'd47,
        SB      = 7'd50,
        SH      = 7'd51,
        SW      = 7'd52,
        ADDIU   = 7'd53,
        HALT    = 7'd54,
        INVALID = 7'd55
    } instr_code_t;

    // Core sequencing states
    typedef enum logic [1:0] {
        FETCH  = 2'd0,
        EXEC1  = 2'd1,
        EXEC2  = 2'd2,
        HALTED = 2'd3
    } cpu_state_t;

endpackage

`default_nettype wire

// ==== hdl/mxu.sv ====
`timescale 1ns/100ps
`default_nettype none

module mxu (
    input  logic                        waitrequest,
    input  logic [mips_pkg::DATA_W-1:0] regdatain,
    input  logic [mips_pkg::DATA_W-1:0] memin,
    input  logic                        fetch,
    input  logic                        exec1,
    input  mips_pkg::instr_code_t       instruction_code,
    input  logic [mips_pkg::DATA_W-1:0] pc_address,
    input  logic [mips_pkg::DATA_W-1:0] alu_r,
    output logic [mips_pkg::DATA_W-1:0] mem_address,
    output logic [mips_pkg::DATA_W-1:0] dataout,
    output logic [mips_pkg::DATA_W-1:0] memout,
    output logic                        read,
    output logic                        write,
    output logic [3:0]                  byteenable,
    output logic                        mem_halt
);

    logic        is_byte;
    logic        is_half;
    logic        is_word;
    logic        is_load;
    logic        is_store;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // ----------------------------------------------------------
    // Access classification
    // ----------------------------------------------------------
    assign is_byte = (instruction_code == mips_pkg::LB)  ||
                     (instruction_code == mips_pkg::LBU) ||
                     (instruction_code == mips_pkg::SB);

    assign is_half = (instruction_code == mips_pkg::LH)  ||
                     (instruction_code == mips_pkg::LHU) ||
                     (instruction_code == mips_pkg::SH);

    assign is_word = (instruction_code == mips_pkg::LW) ||
                     (instruction_code == mips_pkg::SW);

    assign is_load = (instruction_code == mips_pkg::LB)  ||
                     (instruction_code == mips_pkg::LBU) ||
                     (instruction_code == mips_pkg::LH)  ||
                     (instruction_code == mips_pkg::LHU) ||
                     (instruction_code == mips_pkg::LW);

    assign is_store = (instruction_code == mips_pkg::SB) ||
                      (instruction_code == mips_pkg::SH) ||
                      (instruction_code == mips_pkg::SW);

    // ----------------------------------------------------------
    // Bus control
    // ----------------------------------------------------------
    assign mem_address = fetch ? pc_address : alu_r;

    assign read  = fetch || (exec1 && is_load);
    assign write = exec1 && is_store;

    // Stall the control unit until the transfer completes
    assign mem_halt = (read || write) && waitrequest;

    always_comb begin
        if (fetch || is_word) begin
            byteenable = 4'b1111;
        end else if (is_byte) begin
            byteenable = 4'b0001 << mem_address[1:0];
        end else if (is_half) begin
            byteenable = mem_address[1] ? 4'b1100 : 4'b0011;
        end else begin
            byteenable = 4'b0000;
        end
    end

    // Store data copied onto every lane, byteenable picks the live ones
    always_comb begin
        if (instruction_code == mips_pkg::SB) begin
            memout = {4{regdatain[7:0]}};
        end else if (instruction_code == mips_pkg::SH) begin
            memout = {2{regdatain[15:0]}};
        end else begin
            memout = regdatain;
        end
    end

    // ----------------------------------------------------------
    // Load data alignment and extension
    // ----------------------------------------------------------
    always_comb begin
        case (mem_address[1:0])
            2'd0: lane_byte = memin[7:0];
            2'd1: lane_byte = memin[15:8];
            2'd2: lane_byte = memin[23:16];
            default: lane_byte = memin[31:24];
        endcase
        lane_half = mem_address[1] ? memin[31:16] : memin[15:0];
    end

    always_comb begin
        case (instruction_code)
            mips_pkg::LB: begin
                dataout = {{24{lane_byte[7]}}, lane_byte};
            end
            mips_pkg::LBU: begin
                dataout = {24'h000000, lane_byte};
            end
            mips_pkg::LH: begin
                dataout = {{16{lane_half[15]}}, lane_half};
            end
            mips_pkg::LHU: begin
                dataout = {16'h0000, lane_half};
            end
            default: begin
                dataout = memin;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rs,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rt,
    input  logic                            reg_write,
    input  logic [mips_pkg::REG_ADDR_W-1:0] write_addr,
    input  logic [mips_pkg::DATA_W-1:0]     write_data,
    output logic [mips_pkg::DATA_W-1:0]     rs_data,
    output logic [mips_pkg::DATA_W-1:0]     rt_data,
    output logic [mips_pkg::DATA_W-1:0]     register_v0
);

    logic [mips_pkg::DATA_W-1:0] regs [0:(1 << mips_pkg::REG_ADDR_W)-1];

    // Register zero is cleared here and never written afterwards
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << mips_pkg::REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && (write_addr != '0)) begin
            regs[write_addr] <= write_data;
        end
    end

    // Asynchronous read ports
    assign rs_data = regs[rs];
    assign rt_data = regs[rt];

    // v0 lives in register 2
    assign register_v0 = regs[2];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module mips_cpu_tb -o mips_cpu_sim

./obj_dir/mips_cpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "Simulation did not finish"
    exit 1
fi
echo "Simulation passed"

// ==== verif/mips_cpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_cpu_tb;

    logic        clk;
    logic        rst;
    logic [31:0] readdata;
    logic        waitrequest;
    logic [31:0] mem_address;
    logic        read;
    logic        write;
    logic [3:0]  byteenable;
    logic [31:0] writedata;
    logic        halted;
    logic [31:0] register_v0;

    // Word-indexed memory model of 4 KiB
    logic [31:0] mem [0:1023];

    // Program image and expected results of the current test
    logic [31:0] img_addr [$];
    logic [31:0] img_data [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_v0;

    integer      seed;
    logic        stalls_on;
    logic        in_access;
    logic        completed;
    logic [31:0] stall;
    logic [31:0] draw;
    int          errors;
    int          tests_passed;
    int          tests_failed;

    // Bus state of the previous cycle for the stability check
    logic        prev_pending;
    logic [31:0] prev_addr;
    logic [3:0]  prev_be;
    logic        prev_rd;
    logic        prev_wr;

    // Set once rst has been high across a rising edge
    logic        rst_seen;

    mips_cpu dut_i (
        .clk         (clk),
        .rst         (rst),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .mem_address (mem_address),
        .read        (read),
        .write       (write),
        .byteenable  (byteenable),
        .writedata   (writedata),
        .halted      (halted),
        .register_v0 (register_v0)
    );

    always #2 clk = ~clk;

    // Legal lane patterns for a given address
    function automatic logic be_legal(input logic [3:0] be, input logic [1:0] a);
        logic ok;
        ok = (be == (4'b0001 << a));
        if (a == 2'd0 && (be == 4'b1111 || be == 4'b0011)) begin
            ok = 1'b1;
        end
        if (a == 2'd2 && be == 4'b1100) begin
            ok = 1'b1;
        end
        return ok;
    endfunction

    // ----------------------------------------------------------
    // Memory responder driving waitrequest and readdata
    // ----------------------------------------------------------
    always @(posedge clk) begin
        #1;
        if (completed) begin
            in_access = 1'b0;
            completed = 1'b0;
        end
        if ((read || write) && !in_access) begin
            in_access = 1'b1;
            draw = $random(seed);
            stall = stalls_on ? {30'd0, draw[1:0]} : 32'd0;
        end
        if (in_access && stall != 32'd0) begin
            waitrequest = 1'b1;
            stall = stall - 32'd1;
        end else if (in_access) begin
            waitrequest = 1'b0;
            readdata = mem[mem_address[11:2]];
        end else begin
            waitrequest = 1'b1;
            readdata = 32'd0;
        end
    end

    // ----------------------------------------------------------
    // Bus monitor and write commit at the falling edge
    // ----------------------------------------------------------
    always @(negedge clk) begin
        if (rst) begin
            if (rst_seen) begin
                assert (!read && !write && !halted) else begin
                    $display("read, write or halted high during reset at %0t", $time);
                    errors++;
                end
            end
            rst_seen     = 1'b1;
            prev_pending = 1'b0;
        end else begin
            rst_seen = 1'b0;
            assert (!(read && write)) else begin
                $display("read and write both high at %0t", $time);
                errors++;
            end
            if (prev_pending) begin
                assert (mem_address == prev_addr && byteenable == prev_be &&
                        read == prev_rd && write == prev_wr) else begin
                    $display("error at %0t: bus changed while waitrequest high", $time);
                    errors++;
                end
            end
            if (write) begin
                assert (be_legal(byteenable, mem_address[1:0])) else begin
                    $display("error at %0t: byteenable %b at address %h",
                             $time, byteenable, mem_address);
                    errors++;
                end
            end
            assert (!(halted && read)) else begin
                $display("read issued after halt at %0t", $time);
                errors++;
            end
            if (write && !waitrequest) begin
                for (int b = 0; b < 4; b++) begin
                    if (byteenable[b]) begin
                        mem[mem_address[11:2]][8*b +: 8] = writedata[8*b +: 8];
                    end
                end
            end
            prev_pending = (read || write) && waitrequest;
            prev_addr    = mem_address;
            prev_be      = byteenable;
            prev_rd      = read;
            prev_wr      = write;
        end
        if ((read || write) && !waitrequest) begin
            completed = 1'b1;
        end
    end

    // Load the image, reset the core, run to halt and compare
    task automatic run_program(input logic [8*24-1:0] name, input logic stall_en);
        int start_errors;
        int cycles;
        start_errors = errors;
        stalls_on = stall_en;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'h5a00_0000 | i;
        end
        foreach (img_addr[k]) begin
            mem[img_addr[k][11:2]] = img_data[k];
        end
        @(posedge clk);
        #1;
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst <= 1'b0;
        cycles = 0;
        while (!halted && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("core never halted in test %0s", name);
            errors++;
        end else begin
            // A few idle cycles so the monitor sees the bus after halt
            repeat (4) @(negedge clk);
            foreach (exp_addr[k]) begin
                assert (mem[exp_addr[k][11:2]] == exp_data[k]) else begin
                    $display("error at %0t: word %h is %h, expected %h", $time,
                             exp_addr[k], mem[exp_addr[k][11:2]], exp_data[k]);
                    errors++;
                end
            end
            assert (register_v0 == exp_v0) else begin
                $display("error at %0t: v0 is %h, expected %h", $time, register_v0, exp_v0);
                errors++;
            end
        end
        if (errors == start_errors) begin
            tests_passed++;
            $display("test %0s stalls %0d: ok", name, stall_en);
        end else begin
            tests_failed++;
            $display("test %0s stalls %0d: FAILED", name, stall_en);
        end
    endtask

    initial begin
        integer            fd;
        integer            code;
        logic [8*16-1:0]   kw;
        logic [8*24-1:0]   name;
        logic [8*128-1:0]  line;
        logic [31:0]       a;
        logic [31:0]       d;
        logic              have_test;
        clk          = 1'b0;
        rst          = 1'b1;
        readdata     = 32'd0;
        waitrequest  = 1'b1;
        seed         = 32'h83b78c14;
        stalls_on    = 1'b0;
        in_access    = 1'b0;
        completed    = 1'b0;
        stall        = 32'd0;
        prev_pending = 1'b0;
        rst_seen     = 1'b0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        exp_v0       = 32'd0;
        have_test    = 1'b0;
        name         = '0;
        fd = $fopen("verif/program_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/program_input.txt");
            errors++;
        end else begin
            code = $fscanf(fd, "%s", kw);
            while (code == 1) begin
                if (kw == "#") begin
                    code = $fgets(line, fd);
                end else if (kw == "T") begin
                    if (have_test) begin
                        run_program(name, 1'b0);
                        run_program(name, 1'b1);
                    end
                    code = $fscanf(fd, "%s", name);
                    have_test = 1'b1;
                    img_addr.delete();
                    img_data.delete();
                    exp_addr.delete();
                    exp_data.delete();
                    exp_v0 = 32'd0;
                end else if (kw == "M") begin
                    code = $fscanf(fd, "%h %h", a, d);
                    img_addr.push_back(a);
                    img_data.push_back(d);
                end else if (kw == "E") begin
                    code = $fscanf(fd, "%h %h", a, d);
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                end else if (kw == "V") begin
                    code = $fscanf(fd, "%h", exp_v0);
                end
                code = $fscanf(fd, "%s", kw);
            end
            if (have_test) begin
                run_program(name, 1'b0);
                run_program(name, 1'b1);
            end
            $fclose(fd);
        end
        $display("passed %0d failed %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0 && tests_passed > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/program_input.txt ====
# T name | M addr word (image) | E addr word (expected after halt) | V word (expected v0)
# Every test runs twice, once without and once with random wait states
T word_round_trip
M 00000000 8C080100
M 00000004 AC080104
M 00000008 3C021234
M 0000000C 2442FFF0
M 00000010 00000000
M 00000100 CAFEBABE
E 00000104 CAFEBABE
V 1233FFF0
T byte_loads
M 00000000 80080100
M 00000004 AC080110
M 00000008 90090100
M 0000000C AC090114
M 00000010 80080101
M 00000014 AC080118
M 00000018 90090101
M 0000001C AC09011C
M 00000020 80080102
M 00000024 AC080120
M 00000028 90090102
M 0000002C AC090124
M 00000030 80080103
M 00000034 AC080128
M 00000038 90090103
M 0000003C AC09012C
M 00000040 00000000
M 00000100 8192A3B4
E 00000110 FFFFFFB4
E 00000114 000000B4
E 00000118 FFFFFFA3
E 0000011C 000000A3
E 00000120 FFFFFF92
E 00000124 00000092
E 00000128 FFFFFF81
E 0000012C 00000081
V 00000000
T half_loads
M 00000000 84080100
M 00000004 AC080110
M 00000008 94090100
M 0000000C AC090114
M 00000010 84080102
M 00000014 AC080118
M 00000018 94090102
M 0000001C AC09011C
M 00000020 00000000
M 00000100 9234A5C6
E 00000110 FFFFA5C6
E 00000114 0000A5C6
E 00000118 FFFF9234
E 0000011C 00009234
V 00000000
T partial_stores
M 00000000 24087788
M 00000004 A0080100
M 00000008 A0080105
M 0000000C A008010A
M 00000010 A008010F
M 00000014 A4080110
M 00000018 A4080116
M 0000001C 00000000
M 00000100 11223344
M 00000104 11223344
M 00000108 11223344
M 0000010C 11223344
M 00000110 11223344
M 00000114 11223344
E 00000100 11223388
E 00000104 11228844
E 00000108 11883344
E 0000010C 88223344
E 00000110 11227788
E 00000114 77883344
V 00000000
